// ==== gpu_issue_pkg.sv ====
`default_nettype none

package gpu_issue_pkg;

    localparam int num_warps = 4;
    localparam int num_regs  = 16;
    localparam int wid_bits  = $clog2(num_warps);
    localparam int reg_bits  = $clog2(num_regs);
    localparam int xlen      = 32;
    localparam int imm_bits  = 16;

    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_xor  = 4'd4,
        op_addi = 4'd5,
        op_mul  = 4'd6
    } opcode_e;

    // Word holds opcode in 31..28, rd in 27..24, rs1 in 23..20, rs2 in 19..16 and imm in 15..0
    typedef struct packed {
        logic [wid_bits-1:0] wid;
        logic [31:0]         word;
    } fetch_t;

    typedef struct packed {
        logic [wid_bits-1:0] wid;
        opcode_e             opcode;
        logic [reg_bits-1:0] rd;
        logic [reg_bits-1:0] rs1;
        logic [reg_bits-1:0] rs2;
        logic [xlen-1:0]     imm;       // Sign extended
        logic                wb;
        logic [num_regs-1:0] used_regs; // Registers checked against the scoreboard
    } decoded_t;

    typedef struct packed {
        logic [wid_bits-1:0] wid;
        opcode_e             opcode;
        logic [reg_bits-1:0] rd;
        logic [xlen-1:0]     a;
        logic [xlen-1:0]     b;         // rs2 value or imm
    } exec_req_t;

    typedef struct packed {
        logic                valid;
        logic [wid_bits-1:0] wid;
        logic [reg_bits-1:0] rd;
        logic [xlen-1:0]     data;
    } writeback_t;

endpackage

`default_nettype wire

// ==== inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  gpu_issue_pkg::fetch_t in_inst,
    output logic                  in_ready,
    input  logic                  issue,
    output logic                  dec_valid,
    output gpu_issue_pkg::decoded_t dec
);
    import gpu_issue_pkg::*;

    logic load;

    function automatic decoded_t decode(input fetch_t f);
        decoded_t    d;
        logic [3:0]  op_raw;
        op_raw = f.word[31:28];
        d.wid  = f.wid;
        d.rd   = f.word[27:24];
        d.rs1  = f.word[23:20];
        d.rs2  = f.word[19:16];
        d.imm  = {{(xlen - imm_bits){f.word[15]}}, f.word[15:0]};
        if (op_raw <= op_mul) begin
            d.opcode = opcode_e'(op_raw);
        end else begin
            d.opcode = op_nop; // Unknown codes do nothing
        end
        d.wb = (d.opcode != op_nop);

        d.used_regs = '0;
        if (d.wb) begin
            d.used_regs[d.rd] = 1'b1;
        end
        if (d.opcode != op_nop) begin
            d.used_regs[d.rs1] = 1'b1;
        end
        if (d.opcode inside {op_add, op_sub, op_and, op_xor, op_mul}) begin
            d.used_regs[d.rs2] = 1'b1;
        end
        return d;
    endfunction

    assign in_ready = !dec_valid || issue; // Empty or draining this cycle
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (load) begin
            dec_valid <= 1'b1;
        end else if (issue) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dec <= decode(in_inst);
        end
    end

endmodule

`default_nettype wire

// ==== warp_scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module warp_scoreboard #(
    parameter int exe_credits = 4
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 dec_valid,
    input  gpu_issue_pkg::decoded_t              dec,
    output logic                                 issue,
    input  logic                                 release_valid,
    input  logic [gpu_issue_pkg::wid_bits-1:0]   release_wid,
    input  logic [gpu_issue_pkg::reg_bits-1:0]   release_rd,
    input  logic                                 credit_return
);
    import gpu_issue_pkg::*;

    localparam int cred_bits = $clog2(exe_credits + 1);

    // One bit per register of each warp, set while a write is outstanding
    logic [num_warps-1:0][num_regs-1:0] inuse_mask;
    logic [num_warps-1:0][num_regs-1:0] inuse_mask_n;
    logic [cred_bits-1:0]               credits;

    logic hazard;
    logic has_credit;
    logic reserve;

    assign hazard     = |(inuse_mask[dec.wid] & dec.used_regs);
    assign has_credit = (credits != '0);
    assign issue      = dec_valid && !hazard && has_credit;

    // Ops without a result push nothing into the queue
    assign reserve = issue && dec.wb;

    always_comb begin
        inuse_mask_n = inuse_mask;
        if (release_valid) begin
            inuse_mask_n[release_wid][release_rd] = 1'b0;
        end
        if (reserve) begin
            inuse_mask_n[dec.wid][dec.rd] = 1'b1; // Reservation wins over release
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inuse_mask <= '0;
        end else begin
            inuse_mask <= inuse_mask_n;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= cred_bits'(exe_credits);
        end else begin
            case ({reserve, credit_return})
                2'b10: begin
                    credits <= credits - 1'b1;
                end
                2'b01: begin
                    credits <= credits + 1'b1;
                end
                default: begin
                    credits <= credits; // Both or neither
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
    parameter int exe_credits = 4,
    parameter int mul_latency = 3
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       issue,
    input  gpu_issue_pkg::exec_req_t   req,
    output logic                       q_valid,
    output gpu_issue_pkg::writeback_t  q_head,
    input  logic                       pop
);
    import gpu_issue_pkg::*;

    localparam int ptr_bits = (exe_credits > 1) ? $clog2(exe_credits) : 1;
    localparam int cnt_bits = $clog2(exe_credits + 1);

    writeback_t alu_stage;
    writeback_t mul_pipe [mul_latency];
    writeback_t queue [exe_credits];

    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [cnt_bits-1:0] count;
    logic                is_alu;
    logic                is_mul;
    logic [xlen-1:0]     alu_res;
    logic                mul_push;
    logic                alu_push;
    writeback_t          mul_out;

    function automatic logic [ptr_bits-1:0] ptr_add(input logic [ptr_bits-1:0] p, input int n);
        int sum;
        sum = int'(p) + n;
        if (sum >= exe_credits) begin
            sum = sum - exe_credits;
        end
        return ptr_bits'(sum);
    endfunction

    assign is_mul = issue && (req.opcode == op_mul);
    assign is_alu = issue && (req.opcode inside {op_add, op_sub, op_and, op_xor, op_addi});

    always_comb begin
        case (req.opcode)
            op_sub:  alu_res = req.a - req.b;
            op_and:  alu_res = req.a & req.b;
            op_xor:  alu_res = req.a ^ req.b;
            default: alu_res = req.a + req.b; // add and addi
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_stage <= '0;
        end else begin
            alu_stage <= '{valid: is_alu, wid: req.wid, rd: req.rd, data: alu_res};
        end
    end

    // Product formed in the first stage, then carried along
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mul_latency; i++) begin
                mul_pipe[i] <= '0;
            end
        end else begin
            mul_pipe[0] <= '{valid: is_mul, wid: req.wid, rd: req.rd, data: req.a * req.b};
            for (int i = 1; i < mul_latency; i++) begin
                mul_pipe[i] <= mul_pipe[i-1];
            end
        end
    end

    assign mul_out  = mul_pipe[mul_latency-1];
    assign mul_push = mul_out.valid;
    assign alu_push = alu_stage.valid;

    // Multiply result takes the first free slot
    always_ff @(posedge clk) begin
        if (mul_push) begin
            queue[wr_ptr] <= mul_out;
        end
        if (alu_push) begin
            queue[ptr_add(wr_ptr, int'(mul_push))] <= alu_stage;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= ptr_add(wr_ptr, int'(mul_push) + int'(alu_push));
            if (pop) begin
                rd_ptr <= ptr_add(rd_ptr, 1);
            end
            count <= count + cnt_bits'(mul_push) + cnt_bits'(alu_push) - cnt_bits'(pop);
        end
    end

    assign q_valid = (count != '0);

    always_comb begin
        q_head       = queue[rd_ptr];
        q_head.valid = q_valid;
    end

endmodule

`default_nettype wire

// ==== result_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_writeback (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               q_valid,
    input  gpu_issue_pkg::writeback_t          q_head,
    output logic                               pop,
    input  logic [gpu_issue_pkg::wid_bits-1:0] rs1_wid,
    input  logic [gpu_issue_pkg::reg_bits-1:0] rs1_idx,
    input  logic [gpu_issue_pkg::reg_bits-1:0] rs2_idx,
    output logic [gpu_issue_pkg::xlen-1:0]     rs1_data,
    output logic [gpu_issue_pkg::xlen-1:0]     rs2_data,
    output logic                               release_valid,
    output logic [gpu_issue_pkg::wid_bits-1:0] release_wid,
    output logic [gpu_issue_pkg::reg_bits-1:0] release_rd,
    output logic                               credit_return,
    output gpu_issue_pkg::writeback_t          wb
);
    import gpu_issue_pkg::*;

    logic [xlen-1:0] regs [num_warps][num_regs];

    // Drain one entry whenever the queue holds one
    assign pop = q_valid;

    // Both operands belong to the warp being issued
    assign rs1_data = regs[rs1_wid][rs1_idx];
    assign rs2_data = regs[rs1_wid][rs2_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_warps; w++) begin
                for (int r = 0; r < num_regs; r++) begin
                    regs[w][r] <= '0;
                end
            end
        end else if (pop) begin
            regs[q_head.wid][q_head.rd] <= q_head.data; // Readable next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb <= '{valid: pop && q_head.valid, wid: q_head.wid, rd: q_head.rd,
                    data: q_head.data};
        end
    end

    // Scoreboard bit and credit go back at the pop edge
    assign release_valid = pop;
    assign release_wid   = q_head.wid;
    assign release_rd    = q_head.rd;
    assign credit_return = pop;

endmodule

`default_nettype wire

// ==== issue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_top #(
    parameter int exe_credits = 4,
    parameter int mul_latency = 3
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  gpu_issue_pkg::fetch_t     in_inst,
    output logic                      in_ready,
    output gpu_issue_pkg::writeback_t wb
);
    import gpu_issue_pkg::*;

    logic                dec_valid;
    decoded_t            dec;
    logic                issue;
    exec_req_t           req;
    logic                q_valid;
    writeback_t          q_head;
    logic                pop;
    logic [xlen-1:0]     rs1_data;
    logic [xlen-1:0]     rs2_data;
    logic                release_valid;
    logic [wid_bits-1:0] release_wid;
    logic [reg_bits-1:0] release_rd;
    logic                credit_return;

    // addi takes its second operand from the immediate
    assign req = '{wid: dec.wid, opcode: dec.opcode, rd: dec.rd, a: rs1_data,
                   b: (dec.opcode == op_addi) ? dec.imm : rs2_data};

    inst_decode u_decode (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_inst(in_inst),
        .in_ready(in_ready), .issue(issue), .dec_valid(dec_valid), .dec(dec)
    );

    warp_scoreboard #(.exe_credits(exe_credits)) u_scoreboard (
        .clk(clk), .reset(reset), .dec_valid(dec_valid), .dec(dec), .issue(issue),
        .release_valid(release_valid), .release_wid(release_wid),
        .release_rd(release_rd), .credit_return(credit_return)
    );

    exec_unit #(.exe_credits(exe_credits), .mul_latency(mul_latency)) u_exec (
        .clk(clk), .reset(reset), .issue(issue), .req(req),
        .q_valid(q_valid), .q_head(q_head), .pop(pop)
    );

    result_writeback u_writeback (
        .clk(clk), .reset(reset), .q_valid(q_valid), .q_head(q_head), .pop(pop),
        .rs1_wid(dec.wid), .rs1_idx(dec.rs1), .rs2_idx(dec.rs2),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .release_valid(release_valid),
        .release_wid(release_wid), .release_rd(release_rd),
        .credit_return(credit_return), .wb(wb)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real period       = 4.0,
    parameter int  reset_cycles = 3
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(period / 2.0) clk = ~clk;
    end

    // Released on a falling edge after reset_cycles rising edges
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
    end
endmodule

`default_nettype wire

// ==== issue_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_props #(
    parameter int limit    = 4,
    parameter int max_wait = 200
) (
    input logic        clk,
    input logic        reset,
    input logic [31:0] level,
    input logic        rel_valid,
    input logic        rel_hit,
    input logic        wait_valid,
    input logic        wait_done
);
    int unsigned fails = 0;
    int unsigned wait_cycles;

    always_ff @(posedge clk) begin
        if (reset || !wait_valid || wait_done) begin
            wait_cycles <= 0;
        end else begin
            wait_cycles <= wait_cycles + 1; // Cycles the decoded instruction has waited
        end
    end

    level_ok: assert property (@(posedge clk) disable iff (reset) level <= limit)
        else begin
            fails++;
            $error("Level %0d above limit %0d", level, limit);
        end

    release_ok: assert property (@(posedge clk) disable iff (reset) rel_valid |-> rel_hit)
        else begin
            fails++;
            $error("Release of a register that was not in use");
        end

    stall_ok: assert property (@(posedge clk) disable iff (reset) wait_cycles <= max_wait)
        else begin
            fails++;
            $error("Instruction held in decode for over %0d cycles", max_wait);
        end
endmodule

bind warp_scoreboard issue_props #(.limit(exe_credits)) sb_props (
    .clk(clk), .reset(reset), .level(32'(credits)), .rel_valid(release_valid),
    .rel_hit(inuse_mask[release_wid][release_rd]), .wait_valid(dec_valid), .wait_done(issue)
);

bind exec_unit issue_props #(.limit(exe_credits)) q_props (
    .clk(clk), .reset(reset), .level(32'(count)), .rel_valid(1'b0), .rel_hit(1'b1),
    .wait_valid(1'b0), .wait_done(1'b1)
);

`default_nettype wire

// ==== issue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_tb;
    import gpu_issue_pkg::*;

    localparam int n_hazard    = 6;
    localparam int n_random    = 200;
    localparam int n_burst     = 32;
    localparam int total_insts = n_hazard + n_random + n_burst;

    logic       clk;
    logic       reset;
    logic       in_valid;
    fetch_t     in_inst;
    logic       in_ready;
    writeback_t wb;

    integer          seed;
    int              errors = 0;
    int              tests_run = 0;
    int              tests_failed = 0;
    int              wb_count = 0;
    int              wb_expected = 0;
    int              stall_cycles = 0;
    logic [xlen-1:0] model_regs [num_warps][num_regs];
    logic [xlen-1:0] last_wb [num_warps][num_regs];
    writeback_t      pend_q [$]; // Expected results in program order

    tb_clock_gen #(.period(4.0), .reset_cycles(3)) clk_gen (.clk(clk), .reset(reset));

    issue_top #(.exe_credits(4), .mul_latency(3)) dut0 (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_inst(in_inst),
        .in_ready(in_ready), .wb(wb)
    );

    function automatic logic [31:0] enc(input opcode_e op, input logic [3:0] rd,
                                        input logic [3:0] rs1, input logic [3:0] rs2,
                                        input logic [15:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic model_accept(input fetch_t f);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] res;
        logic            writes;
        a      = model_regs[f.wid][f.word[23:20]];
        b      = model_regs[f.wid][f.word[19:16]];
        writes = 1'b1;
        case (f.word[31:28])
            op_add:  res = a + b;
            op_sub:  res = a - b;
            op_and:  res = a & b;
            op_xor:  res = a ^ b;
            op_addi: res = a + {{16{f.word[15]}}, f.word[15:0]};
            op_mul:  res = a * b;
            default: begin
                res    = '0;
                writes = 1'b0; // nop
            end
        endcase
        if (writes) begin
            model_regs[f.wid][f.word[27:24]] = res;
            pend_q.push_back('{valid: 1'b1, wid: f.wid, rd: f.word[27:24], data: res});
            wb_expected++;
        end
    endtask

    // Called on a falling edge; holds the instruction until the port takes it
    task automatic send_inst(input logic [1:0] wid, input logic [31:0] word, input logic gaps);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            in_inst  = '{wid: wid, word: word};
            in_valid = gaps ? (($random(seed) & 1) == 1) : 1'b1;
            if (in_valid && !in_ready) begin
                stall_cycles++;
            end
            if (in_valid && in_ready) begin
                taken = 1'b1;
                model_accept(in_inst);
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (pend_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk); // Room for a stray writeback to show up
        check_value("wb_count", 32'(wb_count), 32'(wb_expected));
    endtask

    task automatic finish_test(input string name, input int mark);
        tests_run++;
        if (errors == mark) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - mark);
        end
    endtask

    always @(negedge clk) begin : wb_monitor
        int idx;
        if (!reset && wb.valid) begin
            wb_count++;
            idx = -1;
            for (int i = 0; i < pend_q.size(); i++) begin
                if (idx < 0 && pend_q[i].wid == wb.wid && pend_q[i].rd == wb.rd) begin
                    idx = i; // Oldest write to this register
                end
            end
            if (idx < 0) begin
                $display("Writeback to warp %0d register %0d had no expected value",
                         wb.wid, wb.rd);
                errors++;
            end else begin
                check_value("wb.data", wb.data, pend_q[idx].data);
                pend_q.delete(idx);
            end
            last_wb[wb.wid][wb.rd] = wb.data;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        int          mark;
        int          asrt_fails;
        seed     = 32'he47a_cc2e;
        in_valid = 1'b0;
        in_inst  = '0;
        for (int w = 0; w < num_warps; w++) begin
            for (int i = 0; i < num_regs; i++) begin
                model_regs[w][i] = '0;
                last_wb[w][i]    = '0;
            end
        end
        @(negedge reset);

        mark = errors;
        check_value("in_ready", 32'(in_ready), 32'd1);
        repeat (5) begin
            check_value("wb.valid", 32'(wb.valid), 32'd0);
            @(negedge clk);
        end
        finish_test("reset", mark);

        mark = errors;
        send_inst(2'd2, enc(op_addi, 4'd1, 4'd0, 4'd0, 16'd7), 1'b0);
        send_inst(2'd2, enc(op_addi, 4'd2, 4'd0, 4'd0, 16'hfffd), 1'b0);
        send_inst(2'd2, enc(op_mul, 4'd3, 4'd1, 4'd2, 16'd0), 1'b0);
        send_inst(2'd2, enc(op_add, 4'd5, 4'd3, 4'd1, 16'd0), 1'b0);
        send_inst(2'd2, enc(op_addi, 4'd5, 4'd5, 4'd0, 16'd100), 1'b0);
        send_inst(2'd2, enc(op_sub, 4'd5, 4'd5, 4'd3, 16'd0), 1'b0);
        drain();
        check_value("warp 2 r3", last_wb[2][3], model_regs[2][3]);
        check_value("warp 2 r5", last_wb[2][5], model_regs[2][5]); // Last of three writes
        finish_test("hazard", mark);

        mark = errors;
        for (int i = 0; i < n_random; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            // Registers 0 to 3 only, so hazards are frequent
            send_inst(r[1:0], {4'(r[31:8] % 7), 2'b00, r[3:2], 2'b00, r[5:4],
                               2'b00, r[7:6], r2[15:0]}, 1'b1);
        end
        drain();
        finish_test("random", mark);

        mark = errors;
        stall_cycles = 0;
        for (int i = 0; i < n_burst; i++) begin
            send_inst(2'(i), enc(op_mul, 4'(4 + i % 8), 4'd1, 4'd2, 16'd0), 1'b0);
        end
        drain();
        if (stall_cycles == 0) begin
            $display("Multiply burst never saw in_ready low");
            errors++;
        end
        finish_test("credits", mark);

        asrt_fails = dut0.u_scoreboard.sb_props.fails + dut0.u_exec.q_props.fails;
        $display("Summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (total_insts * 20) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not finish", total_insts * 20);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
gpu_issue_pkg.sv
inst_decode.sv
warp_scoreboard.sv
exec_unit.sv
result_writeback.sv
issue_top.sv
tb_clock_gen.sv
issue_props.sv
issue_tb.sv

// ==== Bender.yml ====
package:
  name: gpu_issue

sources:
  - gpu_issue_pkg.sv
  - inst_decode.sv
  - warp_scoreboard.sv
  - exec_unit.sv
  - result_writeback.sv
  - issue_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - issue_props.sv
      - issue_tb.sv
